// File: test/dma_cases.txt
# Columns, all hex: src_addr dest_addr length mode resp expected_stopped_on_error
# mode 0 stand-by, 1 host-to-ddr, 2 ddr-to-host (wrap), 3 ddr-to-ddr; resp 0 OKAY, 2 SLVERR, 3 DECERR
00001000 00008000 04 1 0 0
00002000 00009000 10 3 0 0
00003000 0000a000 28 3 0 0
00004000 0000b000 08 2 0 0
00005000 0000c000 06 1 2 1
00006000 0000d000 01 0 0 0
00007000 0000e000 10 2 0 0
00008000 0000f000 0c 3 3 1
00009000 00010000 20 1 0 0
0000a000 00011000 03 3 0 0

// File: verilog.f
+incdir+src
src/axi_types_pkg.sv
src/dma_types_pkg.sv
src/dma_data_fifo.sv
src/read_src_fsm.sv
src/write_dest_fsm.sv
src/dma_engine.sv
test/dma_engine_tb.sv

// File: Makefile
# Verilator build and run of the DMA engine testbench.
VERILATOR ?= verilator
TOP       ?= dma_engine_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv src/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; else echo "TEST PASSED"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/dma_engine_tb.sv
/* DMA engine testbench.
   Runs the transfers of the cases file against AXI memory models with random stalls. */
`timescale 1ns/1ps

module dma_engine_tb
   import axi_types_pkg::*;
   import dma_types_pkg::*;
();

   localparam logic [31:0] DATA_OFFSET = 32'h5a00_0000;   // Source word is its address plus this.

   logic clk, reset_n, go, desc_pending, reset_dispatcher;
   axi_addr_t src_addr, dest_addr, ar_addr, aw_addr;
   dma_len_t length;
   dma_mode_e mode;
   logic done, busy, stopped_on_error;
   wr_state_e wr_state;
   dma_perf_t wr_clk_cnt, wr_valid_cnt;
   logic ar_valid, ar_ready, r_valid, r_last, r_ready;
   logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
   axi_len_t ar_len, aw_len;
   axi_size_t ar_size, aw_size;
   axi_burst_e ar_burst, aw_burst;
   axi_data_t r_data, w_data;
   axi_resp_e b_resp;

   logic [31:0] case_src[$], case_dest[$], case_len[$], case_mode[$], case_resp[$], case_err[$];
   logic [31:0] cur_src, cur_dest, cur_len, cur_mode, cur_resp;
   logic [31:0] rng, rd_base, rd_beat, rd_last;
   logic rd_active, r_taken, b_taken, resp_due;
   int ar_count, aw_count, w_beats, done_count, mismatches, failures, cycles, cycle_limit;
   int active_cycles;   // Cycles from the first offered beat to the last accepted one.

   dma_engine dut_i (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic require_true(input logic cond, input string what);
      assert (cond) else begin
         failures++;
         $display("ERROR at %0t ns: %s", $time, what);
      end
   endtask

   task automatic report_counts();
      $display("Summary: %0d mismatches, %0d other errors, %0d cases", mismatches, failures,
               case_src.size());
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         failures++;
         $display("ERROR: the run did not finish within %0d cycles", cycle_limit);
         report_counts();
         $display("Checks failed");
         $finish;
      end
   end

   // Memory models drive just after the edge.
   always @(posedge clk) begin
      #1;
      rng = xorshift32(rng);
      ar_ready = rng[5] | rng[6];
      aw_ready = rng[7] | rng[8];
      w_ready = rng[9] | rng[10];
      if (!r_valid || r_taken) begin   // A beat on offer is held until accepted.
         r_valid = rd_active && (rng[1:0] != 2'b00);
         r_data = rd_base + 4 * rd_beat + DATA_OFFSET;
         r_last = r_valid && (rd_beat == rd_last);
      end
      r_taken = 1'b0;
      if (b_taken) b_valid = 1'b0;
      b_taken = 1'b0;
      if (resp_due) begin
         b_valid = 1'b1;
         b_resp = axi_resp_e'(cur_resp[1:0]);
         resp_due = 1'b0;
      end
   end

   // Handshakes are sampled mid-cycle, where every signal has settled.
   always @(negedge clk) begin
      if (reset_n) begin
         if (ar_valid && ar_ready) begin
            ar_count++;
            compare_value("ar_addr", ar_addr, cur_src);
            compare_value("ar_len", 32'(ar_len), cur_len - 1);
            compare_value("ar_size", 32'(ar_size), 2);
            compare_value("ar_burst", 32'(ar_burst), 32'(BURST_INCR));
            rd_base = ar_addr;
            rd_last = 32'(ar_len);
            rd_beat = 0;
            rd_active = 1'b1;
         end
         if (r_valid && r_ready) begin
            r_taken = 1'b1;
            if (r_last) rd_active = 1'b0;
            else rd_beat++;
         end
         if (aw_valid && aw_ready) begin
            aw_count++;
            compare_value("aw_addr", aw_addr, cur_dest);
            compare_value("aw_len", 32'(aw_len), cur_len - 1);
            compare_value("aw_size", 32'(aw_size), 2);
            compare_value("aw_burst", 32'(aw_burst), (cur_mode == 32'(DDR_TO_HOST)) ?
                          32'(BURST_WRAP) : 32'(BURST_INCR));
         end
         if ((w_valid || active_cycles > 0) && w_beats < cur_len) begin
            active_cycles++;   // Stalls inside the burst count as active.
         end
         if (w_valid && w_ready) begin
            compare_value("w_data", w_data, cur_src + 4 * w_beats + DATA_OFFSET);
            compare_value("w_last", 32'(w_last), 32'(w_beats == cur_len - 1));
            w_beats++;
            if (w_beats == cur_len) resp_due = 1'b1;   // Response follows the final beat.
         end
         if (b_valid && b_ready) b_taken = 1'b1;
         if (done) done_count++;
      end
   end

   task automatic run_case(input int i);
      cur_src = case_src[i];
      cur_dest = case_dest[i];
      cur_len = case_len[i];
      cur_mode = case_mode[i];
      cur_resp = case_resp[i];
      @(posedge clk);
      #1;
      ar_count = 0;
      aw_count = 0;
      w_beats = 0;
      done_count = 0;
      active_cycles = 0;
      src_addr = cur_src;
      dest_addr = cur_dest;
      length = dma_len_t'(cur_len);
      mode = dma_mode_e'(cur_mode[1:0]);
      go = 1'b1;
      desc_pending = 1'b1;
      do @(negedge clk); while (!done && !stopped_on_error);
      @(posedge clk);
      #1;
      go = 1'b0;
      desc_pending = 1'b0;
      compare_value("stopped_on_error", 32'(stopped_on_error), case_err[i]);
      compare_value("accepted beats", w_beats, cur_len);
      require_true(ar_count == 1 && aw_count == 1, "address handshakes were not one each");
      if (case_err[i] == 0) begin
         require_true(done_count == 1, "done did not pulse exactly once");
         compare_value("busy", 32'(busy), 0);
         compare_value("wr_state", 32'(wr_state), 32'(WR_IDLE));
         compare_value("wr_valid_cnt", 32'(wr_valid_cnt), cur_len);
         compare_value("wr_clk_cnt", 32'(wr_clk_cnt), active_cycles);
      end else begin
         require_true(done_count == 0, "done pulsed on an error response");
         compare_value("wr_state", 32'(wr_state), 32'(WR_ERROR));
      end
      if (stopped_on_error) begin
         reset_dispatcher = 1'b1;
         @(posedge clk);
         #1;
         reset_dispatcher = 1'b0;
         compare_value("wr_state", 32'(wr_state), 32'(WR_IDLE));
         compare_value("stopped_on_error", 32'(stopped_on_error), 0);
      end
   endtask

   initial begin
      int fd;
      int n;
      string line;
      logic [31:0] f_src, f_dest, f_len, f_mode, f_resp, f_err;
      clk = 1'b0;
      reset_n = 1'b0;
      {go, desc_pending, reset_dispatcher} = '0;
      src_addr = '0;
      dest_addr = '0;
      length = '0;
      mode = STAND_BY;
      {ar_ready, r_valid, r_last, aw_ready, w_ready, b_valid} = '0;
      r_data = '0;
      b_resp = OKAY;
      {rd_active, r_taken, b_taken, resp_due} = '0;
      {rd_base, rd_beat, rd_last} = '0;
      rng = 32'hdf664ea6;
      fd = $fopen("test/dma_cases.txt", "r");
      require_true(fd != 0, "cannot open test/dma_cases.txt");
      if (fd != 0) begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h", f_src, f_dest, f_len, f_mode, f_resp,
                           f_err);
               if (n == 6) begin
                  case_src.push_back(f_src);
                  case_dest.push_back(f_dest);
                  case_len.push_back(f_len);
                  case_mode.push_back(f_mode);
                  case_resp.push_back(f_resp);
                  case_err.push_back(f_err);
               end
            end
         end
         $fclose(fd);
      end
      require_true(case_src.size() > 0, "no transfer cases were loaded");
      cycle_limit = 400 * (case_src.size() + 1);
      repeat (4) @(posedge clk);
      @(negedge clk);
      require_true(!(ar_valid | aw_valid | w_valid | b_ready | done | busy | stopped_on_error),
                   "outputs are not idle during reset");
      @(posedge clk);
      #1;
      reset_n = 1'b1;
      for (int i = 0; i < case_src.size(); i++) begin
         run_case(i);
      end
      report_counts();
      if (mismatches == 0 && failures == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: src/dma_engine.sv
/* Single-channel DMA engine.
   Source read machine, data FIFO and destination write machine on two AXI ports. */
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_engine
   import axi_types_pkg::*;
   import dma_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  axi_addr_t  src_addr,
   input  axi_addr_t  dest_addr,
   input  dma_len_t   length,
   input  dma_mode_e  mode,
   input  logic       go,
   input  logic       desc_pending,
   input  logic       reset_dispatcher,
   output logic       done,
   output logic       busy,
   output logic       stopped_on_error,
   output wr_state_e  wr_state,
   output dma_perf_t  wr_clk_cnt,
   output dma_perf_t  wr_valid_cnt,
   output logic       ar_valid,
   input  logic       ar_ready,
   output axi_addr_t  ar_addr,
   output axi_len_t   ar_len,
   output axi_size_t  ar_size,
   output axi_burst_e ar_burst,
   input  logic       r_valid,
   input  axi_data_t  r_data,
   input  logic       r_last,
   output logic       r_ready,
   output logic       aw_valid,
   input  logic       aw_ready,
   output axi_addr_t  aw_addr,
   output axi_len_t   aw_len,
   output axi_size_t  aw_size,
   output axi_burst_e aw_burst,
   output logic       w_valid,
   input  logic       w_ready,
   output axi_data_t  w_data,
   output logic       w_last,
   input  logic       b_valid,
   input  axi_resp_e  b_resp,
   output logic       b_ready
);

   logic      push;
   axi_data_t push_data;
   logic      pop;
   axi_data_t pop_data;
   logic      full;
   logic      not_empty;

   // A dispatcher reset after an error also frees the source machine from DONE_WAIT.
   read_src_fsm src_i (
      .clk, .reset_n, .go, .desc_pending, .wr_done(done | reset_dispatcher),
      .src_addr, .length, .ar_valid, .ar_ready, .ar_addr, .ar_len, .ar_size, .ar_burst,
      .r_valid, .r_data, .r_last, .r_ready, .full, .push, .push_data
   );

   dma_data_fifo #(.DEPTH(1 << `DMA_FIFO_AW)) fifo_i (
      .clk, .reset_n, .push, .push_data, .pop, .pop_data, .full, .not_empty
   );

   write_dest_fsm dest_i (
      .clk, .reset_n, .go, .desc_pending, .reset_dispatcher, .dest_addr, .length, .mode,
      .aw_valid, .aw_ready, .aw_addr, .aw_len, .aw_size, .aw_burst,
      .w_valid, .w_ready, .w_data, .w_last, .b_valid, .b_resp, .b_ready,
      .not_empty, .pop, .pop_data, .done, .busy, .stopped_on_error,
      .wr_state, .wr_clk_cnt, .wr_valid_cnt
   );

endmodule

// File: src/write_dest_fsm.sv
/* Destination write machine.
   Drains the data FIFO into one AXI write burst, checks the response and reports status. */
`timescale 1ns/1ps
`include "dma_defs.svh"

module write_dest_fsm
   import axi_types_pkg::*;
   import dma_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  logic       go,
   input  logic       desc_pending,
   input  logic       reset_dispatcher,
   input  axi_addr_t  dest_addr,
   input  dma_len_t   length,
   input  dma_mode_e  mode,
   output logic       aw_valid,
   input  logic       aw_ready,
   output axi_addr_t  aw_addr,
   output axi_len_t   aw_len,
   output axi_size_t  aw_size,
   output axi_burst_e aw_burst,
   output logic       w_valid,
   input  logic       w_ready,
   output axi_data_t  w_data,
   output logic       w_last,
   input  logic       b_valid,
   input  axi_resp_e  b_resp,
   output logic       b_ready,
   input  logic       not_empty,
   output logic       pop,
   input  axi_data_t  pop_data,
   output logic       done,
   output logic       busy,
   output logic       stopped_on_error,
   output wr_state_e  wr_state,
   output dma_perf_t  wr_clk_cnt,
   output dma_perf_t  wr_valid_cnt
);

   wr_state_e state;
   wr_state_e next;
   dma_len_t  beat_cnt;
   dma_len_t  last_beat;
   logic      resp_ok;
   logic      resp_err;

   assign last_beat = dma_len_t'(length - 1'b1);
   assign resp_ok   = b_valid && (b_resp == OKAY || b_resp == EXOKAY);
   assign resp_err  = b_valid && (b_resp == SLVERR || b_resp == DECERR);
   assign aw_size   = axi_size_t'($clog2(`DMA_DATA_W / 8));
   assign wr_state  = state;

   always_ff @(posedge clk) begin
      if (!reset_n) state <= WR_IDLE;
      else          state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         WR_IDLE:
            if (go && desc_pending) next = WR_ADDR_SETUP;
         WR_ADDR_SETUP:
            if (aw_valid && aw_ready) next = WR_FIFO_EMPTY;
         WR_FIFO_EMPTY:
            if (not_empty) next = WR_RD_FIFO_WR_DEST;
         WR_RD_FIFO_WR_DEST:
            if (pop && w_last) next = WR_WAIT_FOR_WR_RSP;
         WR_WAIT_FOR_WR_RSP:
            if (resp_ok) next = WR_IDLE;
            else if (resp_err) next = WR_ERROR;
         WR_ERROR:
            if (reset_dispatcher) next = WR_IDLE;   // Only the host can release an error.
         default:
            next = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         aw_valid     <= 1'b0;
         busy         <= 1'b0;
         beat_cnt     <= '0;
         wr_clk_cnt   <= '0;
         wr_valid_cnt <= '0;
      end else begin
         unique case (next)
            WR_IDLE: begin
               aw_valid <= 1'b0;
               busy     <= 1'b0;
            end
            WR_ADDR_SETUP: begin
               aw_valid     <= 1'b1;
               busy         <= 1'b1;
               beat_cnt     <= '0;
               wr_clk_cnt   <= '0;
               wr_valid_cnt <= '0;
            end
            default: aw_valid <= 1'b0;
         endcase
         if (pop) begin
            beat_cnt     <= beat_cnt + 1'b1;
            wr_valid_cnt <= wr_valid_cnt + 1'b1;
         end
         if (state == WR_RD_FIFO_WR_DEST) begin
            wr_clk_cnt <= wr_clk_cnt + 1'b1;   // Stall cycles count as active.
         end
      end
   end

   // Device-to-host transfers land in a circular buffer.
   always_ff @(posedge clk) begin
      if (state == WR_IDLE && next == WR_ADDR_SETUP) begin
         aw_addr  <= dest_addr;
         aw_len   <= axi_len_t'(last_beat);
         aw_burst <= (mode == DDR_TO_HOST) ? BURST_WRAP : BURST_INCR;
      end
   end

   always_comb begin
      w_valid          = 1'b0;
      w_data           = '0;
      w_last           = 1'b0;
      pop              = 1'b0;
      b_ready          = 1'b0;
      done             = 1'b0;
      stopped_on_error = 1'b0;
      unique case (state)
         WR_RD_FIFO_WR_DEST: begin
            w_valid = not_empty;
            w_data  = pop_data;
            w_last  = (beat_cnt == last_beat);
            pop     = not_empty && w_ready;   // A beat leaves the FIFO when it is accepted.
         end
         WR_WAIT_FOR_WR_RSP: begin
            b_ready = 1'b1;
            done    = resp_ok;
         end
         WR_ERROR: stopped_on_error = 1'b1;
         default: ;
      endcase
   end

   aw_held_until_ready: assert property (@(posedge clk) disable iff (!reset_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len));

   // The head beat and its last flag hold while the destination stalls.
   w_held_until_ready: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last));

endmodule

// File: src/read_src_fsm.sv
/* Source read machine.
   Issues one AXI read burst per descriptor and pushes each returned beat into the FIFO. */
`timescale 1ns/1ps
`include "dma_defs.svh"

module read_src_fsm
   import axi_types_pkg::*;
   import dma_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  logic       go,
   input  logic       desc_pending,
   input  logic       wr_done,
   input  axi_addr_t  src_addr,
   input  dma_len_t   length,
   output logic       ar_valid,
   input  logic       ar_ready,
   output axi_addr_t  ar_addr,
   output axi_len_t   ar_len,
   output axi_size_t  ar_size,
   output axi_burst_e ar_burst,
   input  logic       r_valid,
   input  axi_data_t  r_data,
   input  logic       r_last,
   output logic       r_ready,
   input  logic       full,
   output logic       push,
   output axi_data_t  push_data
);

   rd_state_e state;
   rd_state_e next;
   dma_len_t  beat_cnt;
   dma_len_t  last_beat;

   assign last_beat = dma_len_t'(length - 1'b1);
   assign ar_size   = axi_size_t'($clog2(`DMA_DATA_W / 8));
   assign ar_burst  = BURST_INCR;   // Source side always reads linearly.

   always_comb begin
      next = state;
      unique case (state)
         RD_IDLE:
            if (go && desc_pending) next = RD_ADDR_SETUP;
         RD_ADDR_SETUP:
            if (ar_valid && ar_ready) next = RD_DATA;
         RD_DATA:
            if (push && r_last) next = RD_DONE_WAIT;
         RD_DONE_WAIT:
            if (wr_done) next = RD_IDLE;   // Stay parked until the write side has finished.
         default:
            next = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= RD_IDLE;
         ar_valid <= 1'b0;
         beat_cnt <= '0;
      end else begin
         state <= next;
         unique case (next)
            RD_ADDR_SETUP: begin
               ar_valid <= 1'b1;
               beat_cnt <= '0;
            end
            default: ar_valid <= 1'b0;
         endcase
         if (push) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   // The request is captured once, on the way out of IDLE.
   always_ff @(posedge clk) begin
      if (state == RD_IDLE && next == RD_ADDR_SETUP) begin
         ar_addr <= src_addr;
         ar_len  <= axi_len_t'(last_beat);
      end
   end

   always_comb begin
      r_ready = 1'b0;
      unique case (state)
         RD_DATA: r_ready = !full;
         default: r_ready = 1'b0;
      endcase
   end

   assign push      = r_valid && r_ready;
   assign push_data = r_data;

   // The memory has to end the burst on exactly the requested beat.
   r_last_on_length: assert property (@(posedge clk) disable iff (!reset_n)
      push |-> (r_last == (beat_cnt == last_beat)));

endmodule

// File: src/dma_data_fifo.sv
/* Data FIFO between the read and write machines.
   Register array with wrap-bit pointers and show-ahead read data. */
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_data_fifo
   import axi_types_pkg::*;
#(
   parameter int DEPTH = `DMA_FIFO_DEPTH
) (
   input  logic      clk,
   input  logic      reset_n,
   input  logic      push,
   input  axi_data_t push_data,
   input  logic      pop,
   output axi_data_t pop_data,
   output logic      full,
   output logic      not_empty
);

   localparam int AW = $clog2(DEPTH);

   axi_data_t     mem [DEPTH];
   logic [AW:0]   wr_ptr;
   logic [AW:0]   rd_ptr;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Same index with different wrap bits means the writer is a full lap ahead.
   assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign not_empty = (wr_ptr != rd_ptr);
   assign pop_data  = mem[rd_ptr[AW-1:0]];   // Head word is visible before the pop.

   push_while_full: assert property (@(posedge clk) disable iff (!reset_n)
      !(push && full));

   pop_while_empty: assert property (@(posedge clk) disable iff (!reset_n)
      !(pop && !not_empty));

endmodule

// File: src/dma_types_pkg.sv
/* DMA descriptor field types, transfer modes and the state encodings of
   the source and destination machines. */
`include "dma_defs.svh"

package dma_types_pkg;

   typedef logic [`DMA_LEN_W-1:0]  dma_len_t;
   typedef logic [`DMA_PERF_W-1:0] dma_perf_t;

   typedef enum logic [1:0] {
      STAND_BY    = 2'b00,
      HOST_TO_DDR = 2'b01,
      DDR_TO_HOST = 2'b10,
      DDR_TO_DDR  = 2'b11
   } dma_mode_e;

   // Both machines are one-hot.
   typedef enum logic [5:0] {
      WR_IDLE            = 6'b000001,
      WR_ADDR_SETUP      = 6'b000010,
      WR_FIFO_EMPTY      = 6'b000100,
      WR_RD_FIFO_WR_DEST = 6'b001000,
      WR_WAIT_FOR_WR_RSP = 6'b010000,
      WR_ERROR           = 6'b100000
   } wr_state_e;

   typedef enum logic [3:0] {
      RD_IDLE       = 4'b0001,
      RD_ADDR_SETUP = 4'b0010,
      RD_DATA       = 4'b0100,
      RD_DONE_WAIT  = 4'b1000
   } rd_state_e;

endpackage

// File: src/axi_types_pkg.sv
/* AXI channel field types and the burst and response encodings. */
`include "dma_defs.svh"

package axi_types_pkg;

   typedef logic [`DMA_ADDR_W-1:0] axi_addr_t;
   typedef logic [`DMA_DATA_W-1:0] axi_data_t;
   typedef logic [7:0]             axi_len_t;    // Beats minus one.
   typedef logic [2:0]             axi_size_t;   // Log2 of bytes per beat.

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

endpackage

// File: src/dma_defs.svh
/* DMA engine shared widths.
   Bus, descriptor, counter and FIFO sizing used by both packages and the RTL. */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// One AXI beat.
`define DMA_DATA_W      32
`define DMA_ADDR_W      32

// Descriptor length is given in beats.
`define DMA_LEN_W       8

// Active cycle and accepted beat counters.
`define DMA_PERF_W      16

// Data FIFO between the source and destination machines.
`define DMA_FIFO_DEPTH  16
`define DMA_FIFO_AW     4

`endif
